// ==== compile.f ====
design/jpegHeaderPkg.sv
design/markerSequencer.sv
design/segmentSkipper.sv
design/dqtReader.sv
design/sofReader.sv
design/sosReader.sv
design/jpegHeaderParser.sv
verif/jpegHeaderTb.sv

// ==== Makefile ====
# Verilator build and run of the JPEG header parser testbench

VERILATOR ?= verilator
TOP       ?= jpegHeaderTb
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= compile.f

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf $(BUILD)

// ==== verif/jpegHeaderTb.sv ====
/* testbench for the JPEG header parser; the FIFO model stalls at random and
   two streams with three colour components are parsed back to back */
module jpegHeaderTb import jpegHeaderPkg::*; ();

   localparam int numComp = 3;

   logic       clk = 1'b0;
   logic       rst = 1'b0;
   logic       dataInEnable = 1'b0;
   fifoWord_t  dataIn = '0;
   logic       decodeStart = 1'b0;
   logic       imageEnd = 1'b0;
   logic       decodeIdle, imageEnable, enableFF00, useByte, useWord;
   dqtWrite_t  dqtWrite;
   imageSize_t imageSize;

   byte_t       stream[$];           // bytes the FIFO model serves
   int          rdPtr = 0;
   int          streamId = 0;        // bumped for each new stream
   int          loadedId = 0;
   int          countedId = 0;
   logic [31:0] stallLfsr = 32'hc6dfd8f4;
   logic [31:0] dataLfsr = 32'hc6dfd8f4;
   dqtWrite_t   gotWrites[$];
   int          gotPos[$];           // FIFO pointer at each write
   logic        expTable;
   byte_t       qValues[64];
   dim_t        expWidth, expHeight;
   int          dqtDataStart, scanStart;
   int          cycles = 0;
   int          cycleLimit = 100;
   int          errorCount = 0;
   int          checks = 0;
   int          testErrors = 0;

   jpegHeaderParser #(.numComponents(numComp)) i_dut (
      .clk, .rst, .dataInEnable, .dataIn, .decodeStart, .decodeIdle,
      .imageEnable, .imageEnd, .enableFF00, .useByte, .useWord, .dqtWrite, .imageSize
   );

   initial begin
      forever #4 clk = ~clk;
   end

   // taps of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(inout logic [31:0] lfsr, input int bits);
      logic [31:0] value;
      logic        feedback;
      value = '0;
      for (int i = 0; i < bits; i++) begin
         feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr     = {lfsr[30:0], feedback};
         value    = {value[30:0], feedback};
      end
      return value;
   endfunction

   function automatic imageSize_t expectedSize(input dim_t width, input dim_t height);
      imageSize_t size;
      size.width      = width;
      size.height     = height;
      size.blockWidth = blockDim_t'((int'(width) + 15) / 16);  // rounded up to whole blocks
      return size;
   endfunction

   function automatic fifoWord_t windowAt(input int ptr);
      fifoWord_t w;
      w = '0;
      for (int i = 0; i < 4; i++) begin
         if (ptr + i < stream.size()) w[31 - 8 * i -: 8] = stream[ptr + i];
      end
      return w;
   endfunction

   // ------------------------------------------------------------
   // FIFO model, write monitor and watchdog
   // ------------------------------------------------------------
   always @(posedge clk) begin : fifoModel
      int nextPtr;
      if (streamId != loadedId) begin
         nextPtr = 0;  // new stream starts at its first byte
         loadedId <= streamId;
      end else if (useWord) begin
         nextPtr = rdPtr + 2;
      end else if (useByte) begin
         nextPtr = rdPtr + 1;
      end else begin
         nextPtr = rdPtr;
      end
      rdPtr        <= nextPtr;
      dataIn       <= windowAt(nextPtr);
      dataInEnable <= (nextPtr + 4 <= stream.size()) && (lfsrStep(stallLfsr, 3) != 32'd7);
   end

   always @(posedge clk) begin : writeMonitor
      if (streamId != countedId) begin
         countedId <= streamId;
         gotWrites.delete();
         gotPos.delete();
      end else if (rst && dqtWrite.enable) begin
         gotWrites.push_back(dqtWrite);
         gotPos.push_back(rdPtr);
      end
   end

   always @(posedge clk) begin : watchdog
      cycles <= cycles + 1;
      if (cycles > cycleLimit) begin
         $display("timeout: the parser made no progress within %0d cycles", cycleLimit);
         $display("** FAIL **");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------
   task automatic checkBit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errorCount++;
         $display("error t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic checkNumber(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errorCount++;
         $display("error t=%0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic checkDqt(input string name, input dqtWrite_t got, input dqtWrite_t exp);
      checks++;
      if (got !== exp) begin
         errorCount++;
         $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkSize(input string name, input imageSize_t got, input imageSize_t exp);
      checks++;
      if (got !== exp) begin
         errorCount++;
         $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic finishTest(input string name);
      if (errorCount == testErrors) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errorCount - testErrors);
      testErrors = errorCount;
   endtask

   // ------------------------------------------------------------
   // stream builder
   // ------------------------------------------------------------
   task automatic pushWord(input logic [15:0] w);
      stream.push_back(w[15:8]);
      stream.push_back(w[7:0]);
   endtask

   task automatic pushFiller(input int count);
      for (int i = 0; i < count; i++) stream.push_back(byte_t'(lfsrStep(dataLfsr, 8)));
   endtask

   task automatic buildStream();
      segLen_t len;
      stream.delete();
      pushWord(MARKER_SOI);
      len = segLen_t'(2 + lfsrStep(dataLfsr, 4));  // length 2 means no payload
      pushWord(MARKER_APP0);
      pushWord(len);
      pushFiller(int'(len) - 2);
      len = segLen_t'(2 + lfsrStep(dataLfsr, 5));
      pushWord(16'hFFFE);                          // COM marker takes the skip path
      pushWord(len);
      pushFiller(int'(len) - 2);
      pushWord(MARKER_DQT);
      pushWord(16'd67);
      expTable = 1'(lfsrStep(dataLfsr, 1));
      stream.push_back(byte_t'(expTable));         // 8-bit precision and the table id
      dqtDataStart = stream.size();
      for (int i = 0; i < 64; i++) begin
         qValues[i] = byte_t'(lfsrStep(dataLfsr, 8));
         stream.push_back(qValues[i]);
      end
      expWidth  = dim_t'(1 + lfsrStep(dataLfsr, 14));
      expHeight = dim_t'(1 + lfsrStep(dataLfsr, 14));
      pushWord(MARKER_SOF0);
      pushWord(segLen_t'(8 + 3 * numComp));
      stream.push_back(8'h08);
      pushWord(expHeight);
      pushWord(expWidth);
      stream.push_back(byte_t'(numComp));
      for (int c = 1; c <= numComp; c++) begin
         stream.push_back(byte_t'(c));
         stream.push_back((c == 1) ? 8'h22 : 8'h11);  // sampling factors
         stream.push_back((c == 1) ? 8'h00 : 8'h01);
      end
      pushWord(MARKER_SOS);
      pushWord(segLen_t'(6 + 2 * numComp));
      stream.push_back(byte_t'(numComp));
      for (int c = 1; c <= numComp; c++) pushWord({byte_t'(c), 8'h00});
      pushWord(16'h003F);                          // spectral selection 0..63
      stream.push_back(8'h00);
      scanStart = stream.size();
      pushFiller(8);
   endtask

   task automatic runStream(input int n);
      dqtWrite_t exp;
      buildStream();
      streamId++;
      cycleLimit += stream.size() * 2 + stream.size() / 2 + 100;
      @(posedge clk);
      decodeStart <= 1'b1;
      @(posedge clk);
      decodeStart <= 1'b0;
      @(negedge clk);
      while (!imageEnable) @(negedge clk);
      checkNumber("dqt write count", gotWrites.size(), 64);
      if (gotPos.size() > 0) checkNumber("first dqt position", gotPos[0], dqtDataStart);
      finishTest($sformatf("stream %0d segment skip", n));
      for (int i = 0; i < gotWrites.size() && i < 64; i++) begin
         exp.enable  = 1'b1;
         exp.tableId = expTable;
         exp.index   = qIndex_t'(i);
         exp.data    = qValues[i];
         checkDqt("dqtWrite", gotWrites[i], exp);
         checkNumber("dqt position", gotPos[i], dqtDataStart + i);
      end
      finishTest($sformatf("stream %0d dqt writes", n));
      checkSize("imageSize", imageSize, expectedSize(expWidth, expHeight));
      finishTest($sformatf("stream %0d sof size", n));
      checkBit("enableFF00", enableFF00, 1'b1);
      checkBit("decodeIdle", decodeIdle, 1'b0);
      checkNumber("fifo pointer", rdPtr, scanStart);
      finishTest($sformatf("stream %0d image start", n));
      @(posedge clk);
      imageEnd <= 1'b1;
      @(negedge clk);
      checkBit("imageEnable", imageEnable, 1'b1);  // held until imageEnd is seen
      @(posedge clk);
      imageEnd <= 1'b0;
      @(negedge clk);
      checkBit("decodeIdle", decodeIdle, 1'b1);    // idle one cycle after imageEnd
      checkBit("imageEnable", imageEnable, 1'b0);
      finishTest($sformatf("stream %0d back to idle", n));
   endtask

   initial begin : testSequence
      repeat (2) @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      checkBit("decodeIdle", decodeIdle, 1'b1);
      checkBit("imageEnable", imageEnable, 1'b0);
      checkBit("enableFF00", enableFF00, 1'b0);
      checkBit("useByte", useByte, 1'b0);
      checkBit("useWord", useWord, 1'b0);
      finishTest("after reset");
      runStream(1);
      runStream(2);  // second start with a fresh stream
      $display("checks %0d, errors %0d", checks, errorCount);
      if (errorCount == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== design/jpegHeaderParser.sv ====
/* JPEG header parser top; the FIFO must show four valid bytes whenever
   dataInEnable is high and advance by the consumed amount before the next edge */
module jpegHeaderParser import jpegHeaderPkg::*; #(
   parameter int numComponents = 3
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       dataInEnable,
   input  fifoWord_t  dataIn,
   input  logic       decodeStart,
   output logic       decodeIdle,
   output logic       imageEnable,
   input  logic       imageEnd,
   output logic       enableFF00,
   output logic       useByte,
   output logic       useWord,
   output dqtWrite_t  dqtWrite,
   output imageSize_t imageSize
);

   logic        skipStart, dqtStart, sofStart, sosStart;
   segConsume_t skipConsume, dqtConsume, sofConsume, sosConsume;

   markerSequencer markerSeq (
      .clk, .rst, .dataInEnable, .dataIn,
      .decodeStart, .decodeIdle, .imageEnd, .imageEnable,
      .skipStart, .dqtStart, .sofStart, .sosStart,
      .skipConsume, .dqtConsume, .sofConsume, .sosConsume,
      .useByte, .useWord
   );

   segmentSkipper skipper (
      .clk, .rst, .start(skipStart), .dataInEnable, .dataIn, .consume(skipConsume)
   );

   dqtReader dqt (
      .clk, .rst, .start(dqtStart), .dataInEnable, .dataIn,
      .consume(dqtConsume), .dqtWrite
   );

   sofReader #(.numComponents(numComponents)) sof (
      .clk, .rst, .start(sofStart), .dataInEnable, .dataIn,
      .consume(sofConsume), .imageSize
   );

   sosReader sos (
      .clk, .rst, .start(sosStart), .dataInEnable, .dataIn,
      .consume(sosConsume), .enableFF00
   );

endmodule

// ==== design/sosReader.sv ====
/* SOS reader; enableFF00 rises on start and is cleared only by reset,
   a component count of zero is not supported */
module sosReader import jpegHeaderPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        start,
   input  logic        dataInEnable,
   input  fifoWord_t   dataIn,
   output segConsume_t consume,
   output logic        enableFF00
);

   typedef enum logic [2:0] {
      SsIdle, SsLength, SsCount, SsComp, SsSpec0, SsSpec1, SsSpec2
   } sosState_t;

   sosState_t state;
   byte_t     compLeft;   // component words still to read

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state      <= SsIdle;
         compLeft   <= '0;
         enableFF00 <= 1'b0;
      end else begin
         case (state)
            SsIdle: begin
               if (start) begin
                  state      <= SsLength;
                  enableFF00 <= 1'b1;  // scan data follows this header
               end
            end
            SsLength: if (dataInEnable) state <= SsCount;
            SsCount: begin
               if (dataInEnable) begin
                  compLeft <= dataIn[31:24];
                  state    <= SsComp;
               end
            end
            SsComp: begin
               if (dataInEnable) begin
                  compLeft <= compLeft - byte_t'(1);
                  if (compLeft == byte_t'(1)) state <= SsSpec0;
               end
            end
            SsSpec0: if (dataInEnable) state <= SsSpec1;  // Ss
            SsSpec1: if (dataInEnable) state <= SsSpec2;  // Se
            SsSpec2: if (dataInEnable) state <= SsIdle;   // Ah/Al
            default: state <= SsIdle;
         endcase
      end
   end

   assign consume.useWord = dataInEnable && (state == SsLength || state == SsComp);
   assign consume.useByte = dataInEnable && (state == SsCount || state == SsSpec0 ||
                            state == SsSpec1 || state == SsSpec2);
   assign consume.segEnd  = dataInEnable && state == SsSpec2;

endmodule

// ==== design/sofReader.sv ====
/* SOF0 reader; the component count is fixed by numComponents and not read
   from the stream, and imageSize is only valid after segEnd */
module sofReader import jpegHeaderPkg::*; #(
   parameter int numComponents = 3
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        start,
   input  logic        dataInEnable,
   input  fifoWord_t   dataIn,
   output segConsume_t consume,
   output imageSize_t  imageSize
);

   // count byte plus id, sampling and table per component
   localparam segLen_t compBytes = segLen_t'(1 + 3 * numComponents);

   typedef enum logic [2:0] {
      SfIdle, SfLength, SfPrecision, SfHeight, SfWidth, SfComp, SfRound, SfShift
   } sofState_t;

   sofState_t state;
   segLen_t   compCount;
   dim_t      width;
   dim_t      height;
   dim_t      blockAcc;     // width rounded up, before the shift
   blockDim_t blockWidth;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state     <= SfIdle;
         compCount <= '0;
      end else begin
         case (state)
            SfIdle:      if (start) state <= SfLength;
            SfLength:    if (dataInEnable) state <= SfPrecision;
            SfPrecision: if (dataInEnable) state <= SfHeight;
            SfHeight:    if (dataInEnable) state <= SfWidth;
            SfWidth: begin
               if (dataInEnable) begin
                  state     <= SfComp;
                  compCount <= '0;
               end
            end
            SfComp: begin
               if (dataInEnable) begin
                  compCount <= compCount + segLen_t'(1);
                  if (compCount == compBytes - segLen_t'(1)) state <= SfRound;
               end
            end
            SfRound: state <= SfShift;
            SfShift: state <= SfIdle;
            default: state <= SfIdle;
         endcase
      end
   end

   // size registers, loaded as the words go by
   always_ff @(posedge clk) begin
      if (state == SfHeight && dataInEnable) height <= dataIn[31:16];
      if (state == SfWidth && dataInEnable) width <= dataIn[31:16];
      if (state == SfRound) blockAcc <= width + dim_t'(15);
      if (state == SfShift) blockWidth <= blockAcc[15:4];
   end

   assign consume.useWord = dataInEnable &&
                            (state == SfLength || state == SfHeight || state == SfWidth);
   assign consume.useByte = dataInEnable && (state == SfPrecision || state == SfComp);
   assign consume.segEnd  = state == SfShift;  // no stream access, ends on compute

   assign imageSize.width      = width;
   assign imageSize.height     = height;
   assign imageSize.blockWidth = blockWidth;

endmodule

// ==== design/dqtReader.sv ====
/* DQT reader for one 8-bit table per segment; the length word is not checked
   and extra tables in the same segment are not supported */
module dqtReader import jpegHeaderPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        start,
   input  logic        dataInEnable,
   input  fifoWord_t   dataIn,
   output segConsume_t consume,
   output dqtWrite_t   dqtWrite
);

   typedef enum logic [1:0] {DqIdle, DqLength, DqTable, DqData} dqtState_t;

   dqtState_t state;
   qIndex_t   index;
   logic      tableBit;
   logic      lastData;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= DqIdle;
         index <= '0;
      end else begin
         case (state)
            DqIdle:   if (start) state <= DqLength;
            DqLength: if (dataInEnable) state <= DqTable;
            DqTable: begin
               if (dataInEnable) begin
                  state <= DqData;
                  index <= '0;
               end
            end
            DqData: begin
               if (dataInEnable) begin
                  index <= index + qIndex_t'(1);  // wraps to 0 after 63
                  if (lastData) state <= DqIdle;
               end
            end
            default: state <= DqIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == DqTable && dataInEnable) tableBit <= dataIn[24];  // Tq bit 0
   end

   assign lastData = index == qIndex_t'(63);

   assign consume.useWord = dataInEnable && state == DqLength;
   assign consume.useByte = dataInEnable && (state == DqTable || state == DqData);
   assign consume.segEnd  = dataInEnable && state == DqData && lastData;

   assign dqtWrite.enable  = dataInEnable && state == DqData;
   assign dqtWrite.tableId = tableBit;
   assign dqtWrite.index   = index;
   assign dqtWrite.data    = dataIn[31:24];

   // a stall holds the write index
   assert property (@(posedge clk) disable iff (!rst) !consume.useByte |=> $stable(index));

endmodule

// ==== design/segmentSkipper.sv ====
/* skips a segment by its length field; a length of two ends on the length word */
module segmentSkipper import jpegHeaderPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        start,
   input  logic        dataInEnable,
   input  fifoWord_t   dataIn,
   output segConsume_t consume
);

   typedef enum logic [1:0] {SkIdle, SkLength, SkBody} skipState_t;

   skipState_t state;
   segLen_t    remaining;   // payload bytes left
   logic       emptyBody;

   assign emptyBody = dataIn[31:16] == segLen_t'(2);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state     <= SkIdle;
         remaining <= '0;
      end else begin
         case (state)
            SkIdle: if (start) state <= SkLength;
            SkLength: begin
               if (dataInEnable) begin
                  remaining <= dataIn[31:16] - segLen_t'(2);
                  state     <= emptyBody ? SkIdle : SkBody;
               end
            end
            SkBody: begin
               if (dataInEnable) begin
                  remaining <= remaining - segLen_t'(1);
                  if (remaining == segLen_t'(1)) state <= SkIdle;
               end
            end
            default: state <= SkIdle;
         endcase
      end
   end

   assign consume.useWord = dataInEnable && state == SkLength;
   assign consume.useByte = dataInEnable && state == SkBody;
   assign consume.segEnd  = dataInEnable && ((state == SkBody && remaining == segLen_t'(1))
                            || (state == SkLength && emptyBody));

endmodule

// ==== design/markerSequencer.sv ====
/* marker sequencer; DHT, DRI, RSTn, EOI and all APPn fall into the skip path,
   and only one segment reader runs at a time */
module markerSequencer import jpegHeaderPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        dataInEnable,
   input  fifoWord_t   dataIn,
   input  logic        decodeStart,
   output logic        decodeIdle,
   input  logic        imageEnd,
   output logic        imageEnable,
   output logic        skipStart,
   output logic        dqtStart,
   output logic        sofStart,
   output logic        sosStart,
   input  segConsume_t skipConsume,
   input  segConsume_t dqtConsume,
   input  segConsume_t sofConsume,
   input  segConsume_t sosConsume,
   output logic        useByte,
   output logic        useWord
);

   typedef enum logic [1:0] {Idle, GetMarker, ReadSegment, ImageRun} seqState_t;

   seqState_t   state;
   segKind_t    kind;
   logic        startPending;  // high in the first ReadSegment cycle
   segConsume_t merged;
   logic        segEnd;

   function automatic segKind_t decodeMarker(input logic [15:0] code);
      case (code)
         MARKER_SOI:  return segSoi;
         MARKER_APP0: return segSkip;
         MARKER_DQT:  return segDqt;
         MARKER_SOF0: return segSof;
         MARKER_SOS:  return segSos;
         default:     return segSkip;  // unknown, skip by length
      endcase
   endfunction

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state        <= Idle;
         kind         <= segNone;
         startPending <= 1'b0;
      end else begin
         startPending <= 1'b0;
         case (state)
            Idle: if (decodeStart) state <= GetMarker;
            GetMarker: begin
               if (dataInEnable) begin
                  kind         <= decodeMarker(dataIn[31:16]);
                  startPending <= 1'b1;
                  state        <= ReadSegment;
               end
            end
            ReadSegment: begin
               if (segEnd) begin
                  state <= (kind == segSos) ? ImageRun : GetMarker;
                  kind  <= segNone;
               end
            end
            ImageRun: if (imageEnd) state <= Idle;  // scan decoder done
            default: state <= Idle;
         endcase
      end
   end

   // ------------------------------------------------------------
   // reader starts and consume merge
   // ------------------------------------------------------------
   assign skipStart = startPending && kind == segSkip;
   assign dqtStart  = startPending && kind == segDqt;
   assign sofStart  = startPending && kind == segSof;
   assign sosStart  = startPending && kind == segSos;

   assign merged = skipConsume | dqtConsume | sofConsume | sosConsume;
   assign segEnd = merged.segEnd || (startPending && kind == segSoi);  // SOI has no body

   assign useByte     = merged.useByte;
   assign useWord     = merged.useWord || (dataInEnable && state == GetMarker);
   assign decodeIdle  = state == Idle;
   assign imageEnable = state == ImageRun;

   // a reader overlapping the marker fetch would show up here
   assert property (@(posedge clk) disable iff (!rst) !(useByte && useWord));
   assert property (@(posedge clk) disable iff (!rst) segEnd |-> state == ReadSegment);

endmodule

// ==== design/jpegHeaderPkg.sv ====
/* shared types for the JPEG header parser; the stream window is big endian,
   so the next byte is always dataIn[31:24] */
package jpegHeaderPkg;

   typedef logic [31:0] fifoWord_t;  // four-byte window, next byte on top
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] segLen_t;    // segment length or byte count
   typedef logic [15:0] dim_t;       // pixels
   typedef logic [11:0] blockDim_t;  // 16-pixel blocks
   typedef logic [5:0]  qIndex_t;    // coefficient index in a table

   // ------------------------------------------------------------
   // marker codes
   // ------------------------------------------------------------
   localparam logic [15:0] MARKER_SOI  = 16'hFFD8;
   localparam logic [15:0] MARKER_APP0 = 16'hFFE0;
   localparam logic [15:0] MARKER_DQT  = 16'hFFDB;
   localparam logic [15:0] MARKER_SOF0 = 16'hFFC0;
   localparam logic [15:0] MARKER_SOS  = 16'hFFDA;

   typedef enum logic [2:0] {
      segNone, segSoi, segSkip, segDqt, segSof, segSos
   } segKind_t;

   typedef struct packed {
      logic useByte;  // one byte taken
      logic useWord;  // two bytes taken
      logic segEnd;   // segment done this cycle
   } segConsume_t;

   // table is a reserved word, hence tableId
   typedef struct packed {
      logic    enable;
      logic    tableId;
      qIndex_t index;
      byte_t   data;
   } dqtWrite_t;

   typedef struct packed {
      dim_t      width;
      dim_t      height;
      blockDim_t blockWidth;
   } imageSize_t;

endpackage
